// ==== verilog/c64_loader_pkg.sv ====
/*
 * Media loader definitions
 * Address and byte types, download indices and the tape image location
 */

package c64_loader_pkg;

	// ====================
	// Memory geometry
	// ====================

	// Main memory address width
	localparam int ADDR_W = 25;

	// One memory address
	typedef logic [ADDR_W-1:0] addr_t;

	// One data byte
	typedef logic [7:0] byte_t;

	// ====================
	// Download indices
	// ====================

	// Program file with a two byte load address header
	localparam byte_t IDX_PRG = 8'd4;

	// Raw tape image
	localparam byte_t IDX_TAP = 8'd6;

	// ====================
	// Tape image area
	// ====================

	// First byte of the tape image in main memory
	localparam addr_t TAP_BASE = 25'h200000;

endpackage

// ==== verilog/prg_tap_loader.sv ====
/*
 * PRG/TAP loader
 * Turns download bytes into pending memory writes at PRG or TAP addresses
 */

`timescale 1ns/1ns

module prg_tap_loader
	import c64_loader_pkg::*;
(
	input  logic  clk_sys,
	input  logic  reset_n,

	input  logic  ioctl_wr_i,
	input  byte_t ioctl_index_i,
	input  addr_t ioctl_addr_i,
	input  byte_t ioctl_data_i,

	input  logic  wr_done_i,
	output logic  wr_req_o,
	output addr_t wr_addr_o,
	output byte_t wr_data_o
);

	logic  wr_req;
	addr_t load_addr;
	logic  is_prg;
	logic  is_tap;

	assign is_prg = (ioctl_index_i == IDX_PRG);
	assign is_tap = (ioctl_index_i == IDX_TAP);

	// ====================
	// Load address and request
	// ====================

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			wr_req    <= 1'b0;
			load_addr <= '0;
		end else begin
			// Arbiter issued the write, move on to the next address
			if (wr_done_i) begin
				wr_req    <= 1'b0;
				load_addr <= load_addr + 1'b1;
			end

			if (ioctl_wr_i) begin
				if (is_prg) begin
					// Load address header, low byte first
					if (ioctl_addr_i == '0) begin
						load_addr <= {{(ADDR_W-8){1'b0}}, ioctl_data_i};
					end else if (ioctl_addr_i == addr_t'(1)) begin
						load_addr[15:8] <= ioctl_data_i;
					end else begin
						wr_req <= 1'b1;
					end
				end else if (is_tap) begin
					// Tape image always starts at its fixed base
					if (ioctl_addr_i == '0) begin
						load_addr <= TAP_BASE;
					end
					wr_req <= 1'b1;
				end
			end
		end
	end

	// Data byte is held until the write goes out
	always_ff @(posedge clk_sys) begin
		if (ioctl_wr_i && (is_tap || (is_prg && ioctl_addr_i > addr_t'(1)))) begin
			wr_data_o <= ioctl_data_i;
		end
	end

	assign wr_req_o  = wr_req;
	assign wr_addr_o = load_addr;

endmodule

// ==== verilog/tape_reader.sv ====
/*
 * Tape reader
 * Tracks tape length and play state, requests tape bytes for the FIFO
 */

`timescale 1ns/1ns

module tape_reader
	import c64_loader_pkg::*;
#(
	parameter int FIFO_DEPTH = 4
)
(
	input  logic  clk_sys,
	input  logic  reset_n,

	input  logic  ioctl_download_i,
	input  byte_t ioctl_index_i,
	input  addr_t ioctl_addr_i,

	input  logic  play_btn_i,
	input  logic  unload_i,
	input  logic  fifo_full_i,

	input  logic  rd_done_i,
	output logic  rd_req_o,
	output addr_t rd_addr_o,
	output logic  tape_playing_o
);

	logic  tape_dl;
	logic  tape_dl_d;
	logic  play_btn_d;
	logic  playing;
	addr_t tap_len;
	addr_t play_idx;

	assign tape_dl = ioctl_download_i && (ioctl_index_i == IDX_TAP);

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			tape_dl_d  <= 1'b0;
			play_btn_d <= 1'b0;
			playing    <= 1'b0;
			tap_len    <= '0;
			play_idx   <= '0;
		end else begin
			tape_dl_d  <= tape_dl;
			play_btn_d <= play_btn_i;

			if (tape_dl) begin
				// Image is being replaced so playback stays parked
				tap_len  <= ioctl_addr_i + 1'b1;
				play_idx <= '0;
				playing  <= 1'b0;
			end else if (unload_i) begin
				tap_len  <= '0;
				play_idx <= '0;
				playing  <= 1'b0;
			end else begin
				// Download just finished
				if (tape_dl_d) playing <= 1'b1;
				if (!play_btn_d && play_btn_i) playing <= ~playing;

				if (rd_done_i) play_idx <= play_idx + 1'b1;

				// Whole image fetched
				if (playing && play_idx == tap_len) playing <= 1'b0;
			end
		end
	end

	assign rd_req_o       = playing && (play_idx < tap_len) && !fifo_full_i;
	assign rd_addr_o      = TAP_BASE + play_idx;
	assign tape_playing_o = playing;

endmodule

// ==== verilog/tape_fifo.sv ====
/*
 * Tape byte FIFO
 * Holds fetched tape bytes in order until the player takes them
 */

`timescale 1ns/1ns

module tape_fifo
	import c64_loader_pkg::*;
#(
	parameter int FIFO_DEPTH = 4
)
(
	input  logic  clk_sys,
	input  logic  reset_n,
	input  logic  flush_i,

	input  logic  push_i,
	input  byte_t push_data_i,
	input  logic  pop_i,

	output byte_t head_o,
	output logic  full_o,
	output logic  empty_o
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	byte_t            mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic             do_push;
	logic             do_pop;

	assign full_o  = (count == (PTR_W+1)'(FIFO_DEPTH));
	assign empty_o = (count == '0);
	assign do_push = push_i && !full_o;
	assign do_pop  = pop_i && !empty_o;

	always_ff @(posedge clk_sys) begin
		if (!reset_n || flush_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
			count <= count + (PTR_W+1)'(do_push) - (PTR_W+1)'(do_pop);
		end
	end

	always_ff @(posedge clk_sys) begin
		if (do_push) mem[wr_ptr] <= push_data_i;
	end

	assign head_o = mem[rd_ptr];

endmodule

// ==== verilog/mem_slot_arbiter.sv ====
/*
 * Memory slot arbiter
 * One access per bus window, loader writes take the slot before tape reads
 */

`timescale 1ns/1ns

module mem_slot_arbiter
	import c64_loader_pkg::*;
(
	input  logic  clk_sys,
	input  logic  reset_n,
	input  logic  slot_i,

	input  logic  wr_req_i,
	input  addr_t wr_addr_i,
	input  byte_t wr_data_i,
	output logic  wr_done_o,

	input  logic  rd_req_i,
	input  addr_t rd_addr_i,
	output logic  rd_done_o,
	output byte_t rd_data_o,

	output logic  mem_ce_o,
	output logic  mem_we_o,
	output addr_t mem_addr_o,
	output byte_t mem_data_o,
	input  byte_t mem_rdata_i
);

	logic slot_d;
	logic slot_fall;
	logic slot_late;
	logic rd_pend;

	// Window opens on the falling edge of the slot level
	assign slot_fall = slot_d && !slot_i;
	// Second high cycle, memory data is valid here
	assign slot_late = slot_d && slot_i;

	always_ff @(posedge clk_sys) begin
		if (!reset_n) begin
			slot_d    <= 1'b0;
			mem_ce_o  <= 1'b0;
			mem_we_o  <= 1'b0;
			wr_done_o <= 1'b0;
			rd_pend   <= 1'b0;
		end else begin
			slot_d    <= slot_i;
			mem_ce_o  <= slot_fall && (wr_req_i || rd_req_i);
			mem_we_o  <= slot_fall && wr_req_i;
			wr_done_o <= slot_fall && wr_req_i;

			if (slot_fall) rd_pend <= !wr_req_i && rd_req_i;
			else if (slot_late) rd_pend <= 1'b0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (slot_fall) begin
			mem_addr_o <= wr_req_i ? wr_addr_i : rd_addr_i;
			mem_data_o <= wr_data_i;
		end
	end

	// A read whose request was withdrawn meanwhile is dropped
	assign rd_done_o = rd_pend && slot_late && rd_req_i;
	assign rd_data_o = mem_rdata_i;

endmodule

// ==== verilog/c64_media_loader.sv ====
/*
 * Media loader top
 * PRG/TAP download into main memory and tape image playback
 */

`timescale 1ns/1ns

module c64_media_loader
	import c64_loader_pkg::*;
#(
	parameter int FIFO_DEPTH = 4
)
(
	input  logic  clk_sys,
	input  logic  reset_n,

	input  logic  ioctl_download_i,
	input  byte_t ioctl_index_i,
	input  logic  ioctl_wr_i,
	input  addr_t ioctl_addr_i,
	input  byte_t ioctl_data_i,
	output logic  wait_o,

	input  logic  slot_i,
	output logic  mem_ce_o,
	output logic  mem_we_o,
	output addr_t mem_addr_o,
	output byte_t mem_data_o,
	input  byte_t mem_rdata_i,

	input  logic  play_btn_i,
	input  logic  unload_i,
	input  logic  tape_pop_i,
	output byte_t tape_data_o,
	output logic  tape_empty_o,
	output logic  tape_playing_o
);

	logic  wr_req;
	addr_t wr_addr;
	byte_t wr_data;
	logic  wr_done;
	logic  rd_req;
	addr_t rd_addr;
	logic  rd_done;
	byte_t rd_data;
	logic  fifo_full;

	// Buffered bytes are stale once a new image arrives or the tape is unloaded
	wire tape_flush = unload_i || (ioctl_download_i && ioctl_index_i == IDX_TAP);

	assign wait_o = wr_req;

	prg_tap_loader i_loader (
		.clk_sys       (clk_sys),
		.reset_n       (reset_n),
		.ioctl_wr_i    (ioctl_wr_i),
		.ioctl_index_i (ioctl_index_i),
		.ioctl_addr_i  (ioctl_addr_i),
		.ioctl_data_i  (ioctl_data_i),
		.wr_done_i     (wr_done),
		.wr_req_o      (wr_req),
		.wr_addr_o     (wr_addr),
		.wr_data_o     (wr_data)
	);

	tape_reader #(.FIFO_DEPTH(FIFO_DEPTH)) i_reader (
		.clk_sys          (clk_sys),
		.reset_n          (reset_n),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.play_btn_i       (play_btn_i),
		.unload_i         (unload_i),
		.fifo_full_i      (fifo_full),
		.rd_done_i        (rd_done),
		.rd_req_o         (rd_req),
		.rd_addr_o        (rd_addr),
		.tape_playing_o   (tape_playing_o)
	);

	tape_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) i_fifo (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.flush_i     (tape_flush),
		.push_i      (rd_done),
		.push_data_i (rd_data),
		.pop_i       (tape_pop_i),
		.head_o      (tape_data_o),
		.full_o      (fifo_full),
		.empty_o     (tape_empty_o)
	);

	mem_slot_arbiter i_arbiter (
		.clk_sys     (clk_sys),
		.reset_n     (reset_n),
		.slot_i      (slot_i),
		.wr_req_i    (wr_req),
		.wr_addr_i   (wr_addr),
		.wr_data_i   (wr_data),
		.wr_done_o   (wr_done),
		.rd_req_i    (rd_req),
		.rd_addr_i   (rd_addr),
		.rd_done_o   (rd_done),
		.rd_data_o   (rd_data),
		.mem_ce_o    (mem_ce_o),
		.mem_we_o    (mem_we_o),
		.mem_addr_o  (mem_addr_o),
		.mem_data_o  (mem_data_o),
		.mem_rdata_i (mem_rdata_i)
	);

endmodule

// ==== verif/tb_c64_media_loader.sv ====
/*
 * Media loader testbench
 * Replays downloads and tape commands from a stimulus file against a memory model
 */

`timescale 1ns/1ns

module tb_c64_media_loader
	import c64_loader_pkg::*;
();

	localparam int CLK_NS = 40;
	// Slot window length in clock cycles
	localparam int WINDOW = 8;

	logic        clk_sys;
	logic        reset_n;
	logic        ioctl_download_i;
	byte_t       ioctl_index_i;
	logic        ioctl_wr_i;
	addr_t       ioctl_addr_i;
	byte_t       ioctl_data_i;
	logic        wait_o;
	logic        slot_i = 1'b0;
	logic        mem_ce_o;
	logic        mem_we_o;
	addr_t       mem_addr_o;
	byte_t       mem_data_o;
	byte_t       mem_rdata_i = '0;
	logic        play_btn_i;
	logic        unload_i;
	logic        tape_pop_i;
	byte_t       tape_data_o;
	logic        tape_empty_o;
	logic        tape_playing_o;

	byte_t       mem_model [addr_t];
	addr_t       exp_addr_q [$];
	byte_t       exp_data_q [$];
	byte_t       tape_bytes [$];
	logic [63:0] op_q [$];
	int          arg_q [$];
	byte_t       byte_q [$];
	int          pop_idx;
	int          total_bytes;
	int          errors;
	int          checks;
	int          wr_seen = 0;
	int          mon_errors = 0;
	int          mon_checks = 0;
	integer      seed;
	logic        reads_blocked;
	logic        wd_armed = 1'b0;
	longint      wd_limit;
	logic [2:0]  slot_cnt = '0;

	c64_media_loader #(.FIFO_DEPTH(4)) i_dut (
		.clk_sys          (clk_sys),
		.reset_n          (reset_n),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_data_i     (ioctl_data_i),
		.wait_o           (wait_o),
		.slot_i           (slot_i),
		.mem_ce_o         (mem_ce_o),
		.mem_we_o         (mem_we_o),
		.mem_addr_o       (mem_addr_o),
		.mem_data_o       (mem_data_o),
		.mem_rdata_i      (mem_rdata_i),
		.play_btn_i       (play_btn_i),
		.unload_i         (unload_i),
		.tape_pop_i       (tape_pop_i),
		.tape_data_o      (tape_data_o),
		.tape_empty_o     (tape_empty_o),
		.tape_playing_o   (tape_playing_o)
	);

	// ====================
	// Clock, slot and memory
	// ====================

	always #(CLK_NS / 2) clk_sys = ~clk_sys;

	// Slot level is low for 6 cycles and high for 2
	always @(posedge clk_sys) begin
		slot_cnt <= slot_cnt + 1'b1;
		slot_i   <= (slot_cnt == 3'd5) || (slot_cnt == 3'd6);
	end

	// Unwritten bytes read back a pattern of the full address
	function automatic byte_t read_byte(input addr_t a);
		if (mem_model.exists(a)) return mem_model[a];
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ {7'b0, a[24]};
	endfunction

	always @(posedge clk_sys) begin
		if (mem_ce_o && mem_we_o) begin
			mem_model[mem_addr_o] = mem_data_o;
			if (wr_seen >= exp_addr_q.size()) begin
				mon_errors++;
				$display("Unexpected memory write of %h at address %h", mem_data_o, mem_addr_o);
			end else begin
				mon_checks++;
				if (mem_addr_o !== exp_addr_q[wr_seen] || mem_data_o !== exp_data_q[wr_seen]) begin
					mon_errors++;
					$display("Mismatch at %0t: write %h at %h, expected %h at %h", $time,
						mem_data_o, mem_addr_o, exp_data_q[wr_seen], exp_addr_q[wr_seen]);
				end
			end
			wr_seen++;
		end else if (mem_ce_o) begin
			mem_rdata_i <= read_byte(mem_addr_o);
			if (reads_blocked) begin
				mon_errors++;
				$display("Tape read at address %h after the tape was unloaded", mem_addr_o);
			end
		end
	end

	// ====================
	// Stimulus file
	// ====================

	task automatic read_stimulus(output logic ok);
		int               fd;
		int               rc;
		int               n;
		int               k;
		int               val;
		logic [63:0]      tok;
		logic [8*128-1:0] rest;
		ok = 1'b0;
		fd = $fopen("verif/tb_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the stimulus file verif/tb_stimulus.txt");
		end else begin
			ok = 1'b1;
			while ($fscanf(fd, "%s", tok) == 1) begin
				if (tok == 64'("#")) begin
					rc = $fgets(rest, fd);
				end else begin
					n = 0;
					if (tok == 64'("prg") || tok == 64'("tap") || tok == 64'("pop") ||
						tok == 64'("mem")) rc = $fscanf(fd, "%h", n);
					op_q.push_back(tok);
					arg_q.push_back(n);
					if (tok == 64'("prg") || tok == 64'("tap") || tok == 64'("mem")) begin
						for (k = 0; k < ((tok == 64'("mem")) ? 1 : n); k++) begin
							rc = $fscanf(fd, "%h", val);
							byte_q.push_back(byte_t'(val));
						end
					end
					if (tok != 64'("mem")) total_bytes += n;
				end
			end
			$fclose(fd);
		end
	endtask

	// ====================
	// Command tasks
	// ====================

	task automatic download_file(input byte_t idx, input int n);
		byte_t b;
		addr_t base;
		int    k;
		logic  wait_exp;
		base = '0;
		@(posedge clk_sys);
		ioctl_index_i    <= idx;
		ioctl_download_i <= 1'b1;
		if (idx == IDX_TAP) begin
			tape_bytes.delete();
			pop_idx = 0;
			reads_blocked <= 1'b0;
		end
		for (k = 0; k < n; k++) begin
			b = byte_q.pop_front();
			@(posedge clk_sys);
			while (wait_o) @(posedge clk_sys);
			ioctl_wr_i   <= 1'b1;
			ioctl_addr_i <= addr_t'(k);
			ioctl_data_i <= b;
			if (idx == IDX_TAP) begin
				tape_bytes.push_back(b);
				exp_addr_q.push_back(TAP_BASE + addr_t'(k));
				exp_data_q.push_back(b);
			end else if (k == 0) begin
				base = addr_t'(b);
			end else if (k == 1) begin
				base[15:8] = b;
			end else begin
				exp_addr_q.push_back(base + addr_t'(k - 2));
				exp_data_q.push_back(b);
			end
			@(posedge clk_sys);
			ioctl_wr_i <= 1'b0;
			// Only data bytes leave a pending write behind, the PRG header bytes do not
			wait_exp = (idx != IDX_PRG) || (k > 1);
			@(posedge clk_sys);
			checks++;
			if (wait_o !== wait_exp) begin
				errors++;
				$display("Mismatch at %0t: wait_o is %b after byte %0d, expected %b", $time,
					wait_o, k, wait_exp);
			end
		end
		@(posedge clk_sys);
		while (wait_o) @(posedge clk_sys);
		ioctl_download_i <= 1'b0;
	endtask

	task automatic pop_one();
		int waited;
		waited = 0;
		@(posedge clk_sys);
		while (tape_empty_o && waited < 8 * WINDOW) begin
			@(posedge clk_sys);
			waited++;
		end
		if (tape_empty_o) begin
			errors++;
			$display("Tape FIFO stayed empty while waiting for byte %0d", pop_idx);
		end else begin
			checks++;
			if (pop_idx >= tape_bytes.size()) begin
				errors++;
				$display("Tape FIFO holds more bytes than the tape image");
			end else if (tape_data_o !== tape_bytes[pop_idx]) begin
				errors++;
				$display("Mismatch at %0t: tape byte %0d is %h, expected %h", $time,
					pop_idx, tape_data_o, tape_bytes[pop_idx]);
			end
			tape_pop_i <= 1'b1;
			@(posedge clk_sys);
			tape_pop_i <= 1'b0;
		end
		pop_idx++;
	endtask

	task automatic press_play();
		@(posedge clk_sys);
		play_btn_i <= 1'b1;
		@(posedge clk_sys);
		play_btn_i <= 1'b0;
	endtask

	task automatic pause_tape();
		int refill;
		refill = 0;
		press_play();
		repeat (2 * WINDOW) @(posedge clk_sys);
		// Drain what was fetched before the pause
		@(posedge clk_sys);
		while (!tape_empty_o) begin
			pop_one();
			@(posedge clk_sys);
		end
		checks++;
		if (tape_playing_o) begin
			errors++;
			$display("Tape still playing after the play button paused it");
		end
		repeat (3 * WINDOW) begin
			@(posedge clk_sys);
			if (!tape_empty_o) refill++;
		end
		if (refill != 0) begin
			errors++;
			$display("Tape FIFO refilled while playback was paused");
		end
	endtask

	task automatic unload_tape();
		@(posedge clk_sys);
		unload_i <= 1'b1;
		@(posedge clk_sys);
		unload_i <= 1'b0;
		repeat (2) @(posedge clk_sys);
		reads_blocked <= 1'b1;
		@(posedge clk_sys);
		checks++;
		if (!tape_empty_o || tape_playing_o) begin
			errors++;
			$display("Unload left the tape FIFO filled or the tape playing");
		end
		repeat (4 * WINDOW) @(posedge clk_sys);
	endtask

	task automatic run_commands();
		logic [63:0] op;
		int          arg;
		int          k;
		while (op_q.size() > 0) begin
			op  = op_q.pop_front();
			arg = arg_q.pop_front();
			if (op == 64'("prg")) begin
				download_file(IDX_PRG, arg);
			end else if (op == 64'("tap")) begin
				download_file(IDX_TAP, arg);
			end else if (op == 64'("mem")) begin
				checks++;
				if (read_byte(addr_t'(arg)) !== byte_q[0]) begin
					errors++;
					$display("Mismatch at %0t: memory %h holds %h, expected %h", $time,
						arg, read_byte(addr_t'(arg)), byte_q[0]);
				end
				void'(byte_q.pop_front());
			end else if (op == 64'("pop")) begin
				for (k = 0; k < arg; k++) begin
					pop_one();
					repeat ($unsigned($random(seed)) % 4) @(posedge clk_sys);
				end
			end else if (op == 64'("pause")) begin
				pause_tape();
			end else if (op == 64'("play")) begin
				press_play();
			end else if (op == 64'("rest")) begin
				while (pop_idx < tape_bytes.size()) pop_one();
				repeat (2) @(posedge clk_sys);
				checks++;
				if (tape_playing_o || !tape_empty_o) begin
					errors++;
					$display("Tape still playing or FIFO not empty after the last byte");
				end
			end else if (op == 64'("unload")) begin
				unload_tape();
			end else begin
				errors++;
				$display("Unknown stimulus command %0s", op);
			end
		end
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin
		logic ok;
		clk_sys          = 1'b0;
		reset_n          = 1'b0;
		ioctl_download_i = 1'b0;
		ioctl_index_i    = '0;
		ioctl_wr_i       = 1'b0;
		ioctl_addr_i     = '0;
		ioctl_data_i     = '0;
		play_btn_i       = 1'b0;
		unload_i         = 1'b0;
		tape_pop_i       = 1'b0;
		reads_blocked    = 1'b0;
		seed             = 32'h76e4f3cd;
		pop_idx          = 0;
		total_bytes      = 0;
		errors           = 0;
		checks           = 0;
		read_stimulus(ok);
		if (ok) begin
			// Every byte gets 16 slot windows plus margin for reset and pauses
			wd_limit = longint'(total_bytes + 16) * 16 * WINDOW * CLK_NS;
			wd_armed = 1'b1;
			repeat (8) @(posedge clk_sys);
			reset_n <= 1'b1;
			run_commands();
			repeat (2 * WINDOW) @(posedge clk_sys);
			if (wr_seen != exp_addr_q.size()) begin
				errors++;
				$display("Only %0d of %0d loader writes reached memory", wr_seen,
					exp_addr_q.size());
			end
		end else begin
			errors++;
		end
		$display("Checks run %0d, errors %0d", checks + mon_checks, errors + mon_errors);
		if (errors + mon_errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	initial begin
		wait (wd_armed);
		#(wd_limit);
		$display("Timeout at %0t, the run did not complete", $time);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== verif/tb_stimulus.txt ====
# One command per line, all numbers hex
# prg/tap <count> <bytes>, mem <addr> <byte>, pop <count>, pause, play, rest, unload

# Program loaded at 0801
prg 08 01 08 a9 05 8d 20 d0 60
mem 0801 a9
mem 0806 60

# Program loaded at c000
prg 05 00 c0 ea ea 00
mem c000 ea
mem c002 00

# Tape image, played back with a pause in the middle
tap 0c 43 36 34 2d 54 41 50 45 2d 52 41 57
mem 200000 43
mem 20000b 57
pop 3
pause
play
pop 2
rest

# Second image, unloaded halfway
tap 0a 11 22 33 44 55 66 77 88 99 aa
pop 2
unload

# Third image after the unload
tap 06 de ad be ef 01 02
mem 200005 02
rest

// ==== flist.f ====
verilog/c64_loader_pkg.sv
verilog/prg_tap_loader.sv
verilog/tape_reader.sv
verilog/tape_fifo.sv
verilog/mem_slot_arbiter.sv
verilog/c64_media_loader.sv
verif/tb_c64_media_loader.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the media loader testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_c64_media_loader -f flist.f -o tb_sim \
	&& ./obj_dir/tb_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "Build or simulation run failed"; exit 1; }

cat sim.log

# The testbench prints its fail message on any error or timeout
grep -q "FAIL: see errors above" sim.log && { echo "Simulation failed"; exit 1; } \
	|| { echo "Simulation passed"; exit 0; }
